//--- logic/cnn_job_pkg.sv
// Job and frame description shared by the row-sequencing controller
package cnn_job_pkg;

    // Width of a row or column index
    localparam int DIM_W = 10;

    // Rows primed into the pixel-feed buffer before execution starts
    localparam int KERNEL_ROWS = 4;

    // Sequence reads issued per output pixel
    localparam int SEQ_CYCLES = 5;

    // Frame size, both fields hold the last index
    typedef struct packed {
        logic [DIM_W-1:0] num_rows;
        logic [DIM_W-1:0] num_cols;
    } job_cfg_t;

    // Controller phases
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        PRIME,
        ACTIVE,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

//--- logic/cnn_seq_pkg.sv
// Sequence BRAM and compute-element side of the controller
package cnn_seq_pkg;

    // Sequence BRAM address width
    localparam int SEQ_ADDR_W = 12;

    // One read command toward the sequence BRAM
    typedef struct packed {
        logic                  en;
        logic [SEQ_ADDR_W-1:0] addr;
    } seq_rd_t;

endpackage

//--- logic/job_fsm.sv
`timescale 1ns/1ps

module job_fsm (
    input  logic                        clk,
    input  logic                        rst,
    // Job handshake
    input  logic                        job_req,
    input  cnn_job_pkg::job_cfg_t       job_cfg,
    output logic                        job_ack,
    // Fetch handshake
    output logic                        fetch_req,
    input  logic                        fetch_ack,
    // Pixel-feed buffer read-out
    output logic                        load_row,
    input  logic                        row_busy,
    input  logic [cnn_job_pkg::DIM_W:0] rows_in,
    // Output row sequencing
    output logic                        run_row,
    input  logic                        row_end,
    input  logic                        frame_end,
    input  logic                        ce_busy,
    output logic                        job_start,
    output cnn_job_pkg::job_cfg_t       cfg
);

    // Row count that ends priming
    localparam logic [cnn_job_pkg::DIM_W:0] PRIME_ROWS =
        (cnn_job_pkg::DIM_W + 1)'(cnn_job_pkg::KERNEL_ROWS);

    cnn_job_pkg::ctrl_state_t    state;
    // Where the fetch path goes once the handshake closes
    cnn_job_pkg::ctrl_state_t    return_state;
    // Set when the row just run was the last of the frame
    logic                        last_row;
    logic [cnn_job_pkg::DIM_W:0] rows_total;

    // Input rows in the frame
    assign rows_total = {1'b0, cfg.num_rows} + 1'b1;

    // Execution waits until the freshly fetched row is read out
    assign run_row = (state == cnn_job_pkg::ACTIVE) && !row_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Phase sequencing and both handshakes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= cnn_job_pkg::IDLE;
            return_state <= cnn_job_pkg::PRIME;
            job_ack      <= 1'b0;
            fetch_req    <= 1'b0;
            load_row     <= 1'b0;
            job_start    <= 1'b0;
            last_row     <= 1'b0;
        end else begin
            // One-cycle strobes
            load_row  <= 1'b0;
            job_start <= 1'b0;
            case (state)
                cnn_job_pkg::IDLE: begin
                    // Accept a job and go straight to the first fetch
                    if (job_req) begin
                        job_start    <= 1'b1;
                        fetch_req    <= 1'b1;
                        return_state <= cnn_job_pkg::PRIME;
                        state        <= cnn_job_pkg::FETCH;
                    end
                end
                cnn_job_pkg::FETCH: begin
                    // Row landed in the pfb, start the read-out
                    if (fetch_req && fetch_ack) begin
                        fetch_req <= 1'b0;
                        load_row  <= 1'b1;
                    end else if (!fetch_req && !fetch_ack) begin
                        state <= return_state;
                    end
                end
                cnn_job_pkg::PRIME: begin
                    // Next kernel row once the previous one is read
                    if (!row_busy) begin
                        if (rows_in == PRIME_ROWS) begin
                            state <= cnn_job_pkg::ACTIVE;
                        end else begin
                            fetch_req <= 1'b1;
                            state     <= cnn_job_pkg::FETCH;
                        end
                    end
                end
                cnn_job_pkg::ACTIVE: begin
                    if (row_end) begin
                        last_row <= frame_end;
                        state    <= cnn_job_pkg::DRAIN;
                    end
                end
                cnn_job_pkg::DRAIN: begin
                    // Let every pulse leave the chain first
                    if (!ce_busy) begin
                        if (last_row || rows_in == rows_total) begin
                            job_ack <= 1'b1;
                            state   <= cnn_job_pkg::DONE;
                        end else begin
                            fetch_req    <= 1'b1;
                            return_state <= cnn_job_pkg::ACTIVE;
                            state        <= cnn_job_pkg::FETCH;
                        end
                    end
                end
                cnn_job_pkg::DONE: begin
                    // Hold ack until the host withdraws the request
                    if (!job_req) begin
                        job_ack <= 1'b0;
                        state   <= cnn_job_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cnn_job_pkg::IDLE;
                end
            endcase
        end
    end

    // Frame size captured on acceptance
    always_ff @(posedge clk) begin
        if (state == cnn_job_pkg::IDLE && job_req) begin
            cfg <= job_cfg;
        end
    end

endmodule

//--- logic/frame_position_counter.sv
`timescale 1ns/1ps

module frame_position_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  cnn_job_pkg::job_cfg_t cfg,
    input  logic                  run_row,
    output logic                  pixel_step,
    output logic                  row_end,
    output logic                  frame_end
);

    localparam int CYC_W = $clog2(cnn_job_pkg::SEQ_CYCLES);
    localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(cnn_job_pkg::SEQ_CYCLES - 1);

    // Cycle within the current output pixel
    logic [CYC_W-1:0]              pix_cyc;
    logic [cnn_job_pkg::DIM_W-1:0] out_col;
    logic [cnn_job_pkg::DIM_W-1:0] out_row;
    // Index of the final output row
    logic [cnn_job_pkg::DIM_W-1:0] last_out_row;

    // Output rows start after the kernel rows are primed
    assign last_out_row = cfg.num_rows - cnn_job_pkg::DIM_W'(cnn_job_pkg::KERNEL_ROWS - 1);

    // End flags are only valid while a row runs
    assign pixel_step = run_row && (pix_cyc == LAST_CYC);
    assign row_end    = pixel_step && (out_col == cfg.num_cols);
    assign frame_end  = row_end && (out_row == last_out_row);

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_cyc <= '0;
            out_col <= '0;
            out_row <= '0;
        end else if (run_row) begin
            if (pixel_step) begin
                pix_cyc <= '0;
            end else begin
                pix_cyc <= pix_cyc + 1'b1;
            end
            // Column steps on the last cycle of each pixel
            if (row_end) begin
                out_col <= '0;
            end else if (pixel_step) begin
                out_col <= out_col + 1'b1;
            end
            // Row count returns to zero for the next job
            if (frame_end) begin
                out_row <= '0;
            end else if (row_end) begin
                out_row <= out_row + 1'b1;
            end
        end
    end

endmodule

//--- logic/pfb_reader.sv
`timescale 1ns/1ps

module pfb_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  cnn_job_pkg::job_cfg_t       cfg,
    input  logic                        load_row,
    output logic                        pfb_rden,
    output logic                        row_busy,
    output logic [cnn_job_pkg::DIM_W:0] rows_in
);

    // Pixels of the current row still in the buffer
    logic [cnn_job_pkg::DIM_W:0] pix_left;
    // Whole frame read, next load begins a new job
    logic                        frame_read;

    assign pfb_rden = (pix_left != '0);
    // Busy already in the load cycle so the FSM never sees a gap
    assign row_busy = load_row || pfb_rden;

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_left   <= '0;
            rows_in    <= '0;
            frame_read <= 1'b0;
        end else if (load_row) begin
            pix_left <= {1'b0, cfg.num_cols} + 1'b1;
            if (frame_read) begin
                rows_in    <= '0;
                frame_read <= 1'b0;
            end
        end else if (pfb_rden) begin
            pix_left <= pix_left - 1'b1;
            // Last pixel of the row
            if (pix_left == 1) begin
                rows_in    <= rows_in + 1'b1;
                frame_read <= (rows_in == {1'b0, cfg.num_rows});
            end
        end
    end

endmodule

//--- logic/seq_read_gen.sv
`timescale 1ns/1ps

module seq_read_gen #(
    parameter int SEQ_DEPTH = 640
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 job_start,
    input  logic                 run_row,
    output cnn_seq_pkg::seq_rd_t seq_rd
);

    // Wrap point of the sequence program
    localparam logic [cnn_seq_pkg::SEQ_ADDR_W-1:0] ADDR_LAST =
        cnn_seq_pkg::SEQ_ADDR_W'(SEQ_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rd.en   <= 1'b0;
            seq_rd.addr <= '0;
        end else begin
            // One read per running cycle
            seq_rd.en <= run_row;
            if (job_start) begin
                seq_rd.addr <= '0;
            end else if (seq_rd.en) begin
                // Address runs on across output rows
                if (seq_rd.addr == ADDR_LAST) begin
                    seq_rd.addr <= '0;
                end else begin
                    seq_rd.addr <= seq_rd.addr + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/ce_execute_chain.sv
`timescale 1ns/1ps

module ce_execute_chain #(
    parameter int NUM_CE      = 8,
    parameter int SEQ_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_en,
    output logic [NUM_CE-1:0] ce_execute,
    output logic              ce_busy
);

    // BRAM latency stages followed by one stage per compute element
    localparam int PIPE_LEN = SEQ_LATENCY + NUM_CE - 1;

    // Bit k holds the read enable delayed k+1 cycles
    logic [PIPE_LEN-1:0] pipe_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_q <= '0;
        end else begin
            pipe_q <= {pipe_q[PIPE_LEN-2:0], seq_en};
        end
    end

    // First element fires SEQ_LATENCY cycles after its read
    assign ce_execute = pipe_q[PIPE_LEN-1:SEQ_LATENCY-1];

    // Includes the read being issued this cycle
    assign ce_busy = seq_en || (|pipe_q);

endmodule

//--- logic/quad_ctrl_top.sv
`timescale 1ns/1ps

module quad_ctrl_top #(
    parameter int NUM_CE      = 8,
    parameter int SEQ_DEPTH   = 640,
    parameter int SEQ_LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    // Host side
    input  logic                  job_req,
    input  cnn_job_pkg::job_cfg_t job_cfg,
    output logic                  job_ack,
    // Row fetch side
    output logic                  fetch_req,
    input  logic                  fetch_ack,
    output logic                  pfb_rden,
    // Sequence BRAM and compute elements
    output cnn_seq_pkg::seq_rd_t  seq_rd,
    output logic [NUM_CE-1:0]     ce_execute
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////////////////////

    // Frame size latched at job start
    cnn_job_pkg::job_cfg_t        cfg;
    logic                         job_start;
    logic                         load_row;
    logic                         row_busy;
    // Completed input rows of the current job
    logic [cnn_job_pkg::DIM_W:0]  rows_in;
    logic                         run_row;
    logic                         row_end;
    logic                         frame_end;
    logic                         ce_busy;

    job_fsm u_job_fsm (
        .clk       (clk),
        .rst       (rst),
        .job_req   (job_req),
        .job_cfg   (job_cfg),
        .job_ack   (job_ack),
        .fetch_req (fetch_req),
        .fetch_ack (fetch_ack),
        .load_row  (load_row),
        .row_busy  (row_busy),
        .rows_in   (rows_in),
        .run_row   (run_row),
        .row_end   (row_end),
        .frame_end (frame_end),
        .ce_busy   (ce_busy),
        .job_start (job_start),
        .cfg       (cfg)
    );

    // Pixel boundary is consumed inside the counter only
    frame_position_counter u_frame_position_counter (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .run_row    (run_row),
        .pixel_step (),
        .row_end    (row_end),
        .frame_end  (frame_end)
    );

    pfb_reader u_pfb_reader (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .load_row (load_row),
        .pfb_rden (pfb_rden),
        .row_busy (row_busy),
        .rows_in  (rows_in)
    );

    seq_read_gen #(
        .SEQ_DEPTH (SEQ_DEPTH)
    ) u_seq_read_gen (
        .clk       (clk),
        .rst       (rst),
        .job_start (job_start),
        .run_row   (run_row),
        .seq_rd    (seq_rd)
    );

    ce_execute_chain #(
        .NUM_CE      (NUM_CE),
        .SEQ_LATENCY (SEQ_LATENCY)
    ) u_ce_execute_chain (
        .clk        (clk),
        .rst        (rst),
        .seq_en     (seq_rd.en),
        .ce_execute (ce_execute),
        .ce_busy    (ce_busy)
    );

endmodule

//--- verif/quad_ctrl_assertions.sv
`timescale 1ns/1ps

module quad_ctrl_assertions #(
    parameter int NUM_CE = 8
) (
    input logic              clk,
    input logic              rst,
    input logic              job_req,
    input logic              job_ack,
    input logic              fetch_req,
    input logic              fetch_ack,
    input logic [NUM_CE-1:0] ce_execute
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Request held until the row is in the buffer
    fetch_req_held: assert property (@(posedge clk) disable iff (rst)
        fetch_req && !fetch_ack |=> fetch_req)
        else begin
            $error("fetch_req dropped before fetch_ack");
            fail_count++;
        end

    // Job done flag released only after the host withdraws
    job_ack_release: assert property (@(posedge clk) disable iff (rst)
        $fell(job_ack) |-> !$past(job_req))
        else begin
            $error("job_ack fell while job_req was high");
            fail_count++;
        end

    // One stage per compute element
    for (genvar i = 1; i < NUM_CE; i++) begin : g_chain
        chain_shift: assert property (@(posedge clk) disable iff (rst)
            ce_execute[i] == $past(ce_execute[i-1]))
            else begin
                $error("ce_execute[%0d] does not follow the previous stage", i);
                fail_count++;
            end
    end

endmodule

bind quad_ctrl_top quad_ctrl_assertions #(
    .NUM_CE (NUM_CE)
) u_quad_ctrl_assertions (
    .clk        (clk),
    .rst        (rst),
    .job_req    (job_req),
    .job_ack    (job_ack),
    .fetch_req  (fetch_req),
    .fetch_ack  (fetch_ack),
    .ce_execute (ce_execute)
);

//--- verif/quad_ctrl_checker.sv
`timescale 1ns/1ps

module quad_ctrl_checker #(
    parameter int NUM_CE      = 8,
    parameter int SEQ_DEPTH   = 640,
    parameter int SEQ_LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  job_req,
    input  cnn_job_pkg::job_cfg_t job_cfg,
    input  logic                  job_ack,
    input  logic                  fetch_req,
    input  logic                  fetch_ack,
    input  logic                  pfb_rden,
    input  cnn_seq_pkg::seq_rd_t  seq_rd,
    input  logic [NUM_CE-1:0]     ce_execute,
    output int                    error_count,
    output int                    tests_done,
    output int                    tests_failed
);

    // Frame of the job in progress
    cnn_job_pkg::job_cfg_t cur_cfg;
    logic                  in_job;
    logic                  job_seen;
    // A row was fetched and its pixels are being counted
    logic                  row_open;
    logic                  addr_bad;
    logic                  lat_bad;
    logic                  prev_job_req;
    logic                  prev_job_ack;
    logic                  prev_fetch_req;
    logic                  prev_fetch_ack;
    // Read enables of earlier cycles, bit k is k+1 cycles back
    logic [31:0]           en_hist;
    int                    job_num;
    int                    fetches;
    int                    row_pixels;
    int                    job_pixels;
    int                    reads;
    int                    ce_pulses;
    // Next sequence address the model expects
    int                    exp_addr;
    int                    errors_at_start;
    logic                  outputs_quiet;

    // Everything except job_ack, X counts as active
    assign outputs_quiet = (fetch_req === 1'b0) && (pfb_rden === 1'b0) &&
                           (seq_rd.en === 1'b0) && (ce_execute === '0);

    initial begin
        error_count    = 0;
        tests_done     = 0;
        tests_failed   = 0;
        in_job         = 1'b0;
        job_seen       = 1'b0;
        row_open       = 1'b0;
        addr_bad       = 1'b0;
        lat_bad        = 1'b0;
        prev_job_req   = 1'b0;
        prev_job_ack   = 1'b0;
        prev_fetch_req = 1'b0;
        prev_fetch_ack = 1'b0;
        en_hist        = '0;
        job_num        = 0;
    end

    task automatic report_problem(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED job %0d %s expected %0d actual %0d",
                     job_num, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_job();
        if (in_job) begin
            report_problem("new job request while a job is open");
        end
        job_num++;
        cur_cfg         = job_cfg;
        in_job          = 1'b1;
        job_seen        = 1'b1;
        row_open        = 1'b0;
        addr_bad        = 1'b0;
        lat_bad         = 1'b0;
        fetches         = 0;
        row_pixels      = 0;
        job_pixels      = 0;
        reads           = 0;
        ce_pulses       = 0;
        exp_addr        = 0;
        errors_at_start = error_count;
    endtask

    task automatic finish_job();
        int nr;
        int nc;
        int exp_reads;
        nr = int'(cur_cfg.num_rows);
        nc = int'(cur_cfg.num_cols);
        // One output row per input row beyond the primed kernel window
        exp_reads = cnn_job_pkg::SEQ_CYCLES * (nc + 1) *
                    (nr + 2 - cnn_job_pkg::KERNEL_ROWS);
        if (row_open) begin
            check_value("pixel reads of last row", nc + 1, row_pixels);
        end
        check_value("fetch handshakes", nr + 1, fetches);
        check_value("pixel reads in frame", (nr + 1) * (nc + 1), job_pixels);
        check_value("sequence reads", exp_reads, reads);
        check_value("last stage execute pulses", exp_reads, ce_pulses);
        tests_done++;
        if (error_count == errors_at_start) begin
            $display("test %0d (rows %0d, cols %0d): passed", job_num, nr + 1, nc + 1);
        end else begin
            tests_failed++;
            $display("test %0d (rows %0d, cols %0d): failed with %0d errors",
                     job_num, nr + 1, nc + 1, error_count - errors_at_start);
        end
        in_job = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sampled mid-cycle, inputs change just after the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            if (job_ack !== 1'b0 || !outputs_quiet) begin
                report_problem("outputs not low during reset");
            end
            prev_job_req   = 1'b0;
            prev_job_ack   = 1'b0;
            prev_fetch_req = 1'b0;
            prev_fetch_ack = 1'b0;
            en_hist        = '0;
        end else begin
            // Nothing runs between jobs
            if (!in_job && !outputs_quiet) begin
                report_problem("controller active with no job open");
            end
            if (!job_seen && job_ack !== 1'b0) begin
                report_problem("job_ack high before any job");
            end
            if (fetch_req && pfb_rden) begin
                report_problem("pfb_rden high during a fetch request");
            end
            if (prev_job_ack && !job_ack && prev_job_req) begin
                report_problem("job_ack fell before job_req fell");
            end
            if (job_req && !prev_job_req) begin
                start_job();
            end
            if (in_job) begin
                // Pixel count of the previous row closes at the next fetch
                if (fetch_req && !prev_fetch_req && row_open) begin
                    check_value("pixel reads of a row", int'(cur_cfg.num_cols) + 1, row_pixels);
                    row_open = 1'b0;
                end
                if (fetch_ack && !prev_fetch_ack) begin
                    row_open   = 1'b1;
                    row_pixels = 0;
                end
                if (!fetch_ack && prev_fetch_ack) begin
                    fetches++;
                end
                if (pfb_rden) begin
                    row_pixels++;
                    job_pixels++;
                end
                if (seq_rd.en) begin
                    if (int'(seq_rd.addr) != exp_addr && !addr_bad) begin
                        check_value("sequence address", exp_addr, int'(seq_rd.addr));
                        addr_bad = 1'b1;
                    end
                    exp_addr = (exp_addr + 1) % SEQ_DEPTH;
                    reads++;
                end
                // First stage follows the read by the BRAM latency
                if (ce_execute[0] != en_hist[SEQ_LATENCY-1] && !lat_bad) begin
                    check_value("first stage execute",
                                int'(en_hist[SEQ_LATENCY-1]),
                                int'(ce_execute[0]));
                    lat_bad = 1'b1;
                end
                if (ce_execute[NUM_CE-1]) begin
                    if (reads == 0) begin
                        report_problem("execute pulse before the first sequence read");
                    end
                    ce_pulses++;
                end
            end
            if (job_ack && !prev_job_ack) begin
                if (in_job) begin
                    finish_job();
                end else begin
                    report_problem("job_ack raised with no job open");
                end
            end
            en_hist        = {en_hist[30:0], seq_rd.en};
            prev_job_req   = job_req;
            prev_job_ack   = job_ack;
            prev_fetch_req = fetch_req;
            prev_fetch_ack = fetch_ack;
        end
    end

endmodule

//--- verif/quad_ctrl_tb.sv
`timescale 1ns/1ps

module quad_ctrl_tb;

    localparam int NUM_CE      = 8;
    // Small wrap point so the address wraps inside every job
    localparam int SEQ_DEPTH   = 37;
    localparam int SEQ_LATENCY = 3;
    localparam int NUM_JOBS    = 6;
    // At most num_rows+1 fetches per job
    localparam int MAX_FETCH   = 10;

    logic                  clk;
    logic                  rst;
    logic                  job_req;
    cnn_job_pkg::job_cfg_t job_cfg;
    logic                  job_ack;
    logic                  fetch_req;
    logic                  fetch_ack;
    logic                  pfb_rden;
    cnn_seq_pkg::seq_rd_t  seq_rd;
    logic [NUM_CE-1:0]     ce_execute;

    int error_count;
    int tests_done;
    int tests_failed;

    // Jobs and handshake delays, all drawn before reset
    cnn_job_pkg::job_cfg_t jobs [NUM_JOBS];
    int                    release_delay [NUM_JOBS];
    int                    fetch_delay [NUM_JOBS*MAX_FETCH];
    logic [31:0]           rng_state;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    quad_ctrl_top #(
        .NUM_CE      (NUM_CE),
        .SEQ_DEPTH   (SEQ_DEPTH),
        .SEQ_LATENCY (SEQ_LATENCY)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .job_req    (job_req),
        .job_cfg    (job_cfg),
        .job_ack    (job_ack),
        .fetch_req  (fetch_req),
        .fetch_ack  (fetch_ack),
        .pfb_rden   (pfb_rden),
        .seq_rd     (seq_rd),
        .ce_execute (ce_execute)
    );

    quad_ctrl_checker #(
        .NUM_CE      (NUM_CE),
        .SEQ_DEPTH   (SEQ_DEPTH),
        .SEQ_LATENCY (SEQ_LATENCY)
    ) checks (
        .clk          (clk),
        .rst          (rst),
        .job_req      (job_req),
        .job_cfg      (job_cfg),
        .job_ack      (job_ack),
        .fetch_req    (fetch_req),
        .fetch_ack    (fetch_ack),
        .pfb_rden     (pfb_rden),
        .seq_rd       (seq_rd),
        .ce_execute   (ce_execute),
        .error_count  (error_count),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_value(input int span, output int value);
        rng_state = xorshift32(rng_state);
        value = int'(rng_state % 32'(span));
    endtask

    // Rising edge plus input hold delay
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Host side of one job
    task automatic run_job(input int j);
        job_cfg = jobs[j];
        job_req = 1'b1;
        while (!job_ack) step();
        repeat (release_delay[j]) step();
        job_req = 1'b0;
        while (job_ack) step();
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fetch side, one row per request after a random delay
    initial begin : fetch_responder
        int idx;
        idx       = 0;
        fetch_ack = 1'b0;
        forever begin
            step();
            if (fetch_req) begin
                repeat (fetch_delay[idx % (NUM_JOBS * MAX_FETCH)]) step();
                idx++;
                fetch_ack = 1'b1;
                while (fetch_req) step();
                fetch_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job list, reset and the final verdict
    ////////////////////////////////////////////////////////////////////////////

    initial begin : host
        int nr;
        int nc;
        rst       = 1'b1;
        job_req   = 1'b0;
        job_cfg   = '0;
        rng_state = 32'h55a7_b310;
        for (int j = 0; j < NUM_JOBS; j++) begin
            draw_value(7, nr);
            nr = nr + 3;
            draw_value(16, nc);
            draw_value(4, release_delay[j]);
            jobs[j].num_rows = cnn_job_pkg::DIM_W'(nr);
            jobs[j].num_cols = cnn_job_pkg::DIM_W'(nc);
            cycle_limit += (nr + 1) * (nc + 9) +
                           cnn_job_pkg::SEQ_CYCLES * (nc + 1) * (nr + 1) + NUM_CE + 20;
        end
        for (int k = 0; k < NUM_JOBS * MAX_FETCH; k++) begin
            draw_value(8, fetch_delay[k]);
        end
        cycle_limit = 2 * cycle_limit;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        repeat (4) step();
        $display("tests run %0d of %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_done, NUM_JOBS, tests_failed, error_count,
                 UUT.u_quad_ctrl_assertions.fail_count);
        if (error_count == 0 && tests_done == NUM_JOBS &&
            UUT.u_quad_ctrl_assertions.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Run limit scaled from the drawn jobs
    always @(posedge clk) begin
        if (!rst) begin
            cycle_count++;
        end
        if (cycle_count > cycle_limit) begin
            $display("timeout: jobs not finished after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

//--- Bender.yml
package:
  name: quad_ctrl

sources:
  - files:
      - logic/cnn_job_pkg.sv
      - logic/cnn_seq_pkg.sv
      - logic/job_fsm.sv
      - logic/frame_position_counter.sv
      - logic/pfb_reader.sv
      - logic/seq_read_gen.sv
      - logic/ce_execute_chain.sv
      - logic/quad_ctrl_top.sv
  - target: simulation
    files:
      - verif/quad_ctrl_assertions.sv
      - verif/quad_ctrl_checker.sv
      - verif/quad_ctrl_tb.sv

//--- all.f
logic/cnn_job_pkg.sv
logic/cnn_seq_pkg.sv
logic/job_fsm.sv
logic/frame_position_counter.sv
logic/pfb_reader.sv
logic/seq_read_gen.sv
logic/ce_execute_chain.sv
logic/quad_ctrl_top.sv
verif/quad_ctrl_assertions.sv
verif/quad_ctrl_checker.sv
verif/quad_ctrl_tb.sv
